/* tb.f */
+incdir+tests
hdl/FrontTypes.sv
hdl/OpDecoder.sv
hdl/FetchStage.sv
hdl/DecodeStage.sv
hdl/RegReadStage.sv
hdl/FrontEnd.sv
tests/FrontEndTb.sv

/* Bender.yml */
package:
  name: front_end

sources:
  - files:
      - hdl/FrontTypes.sv
      - hdl/OpDecoder.sv
      - hdl/FetchStage.sv
      - hdl/DecodeStage.sv
      - hdl/RegReadStage.sv
      - hdl/FrontEnd.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/FrontEndTb.sv

/* tests/FrontEndModel.svh */
`ifndef FRONT_END_MODEL_SVH
`define FRONT_END_MODEL_SVH

data_t shadow [32];  // expected register file contents

function automatic data_t shadowRead(reg_addr_t addr);
    return (addr == 5'd0) ? '0 : shadow[addr];  // x0 is hardwired
endfunction

function automatic void shadowWrite(reg_addr_t addr, data_t value);
    if (addr != 5'd0) begin
        shadow[addr] = value;
    end
endfunction

// alt selects sub or sra
function automatic AluFunc aluRef(logic alt, logic [2:0] f3);
    AluFunc byFunct3 [8];
    byFunct3 = '{AluFunc_Add, AluFunc_Sll, AluFunc_Slt, AluFunc_Sltu,
                 AluFunc_Xor, AluFunc_Srl, AluFunc_Or, AluFunc_And};
    if (alt) begin
        return (f3 == 3'd0) ? AluFunc_Sub : AluFunc_Sra;
    end
    return byFunct3[f3];
endfunction

function automatic Op refDecode(insn_t w);
    Op          o;
    logic [2:0] f3;
    logic [6:0] f7;
    data_t      immI;
    f3   = w[14:12];
    f7   = w[31:25];
    immI = {{20{w[31]}}, w[31:20]};
    o    = '0;
    o.opClass = OpClass_Unknown;
    case (w[6:0])
        7'b0110111, 7'b0010111: o = '{w[5] ? OpClass_Lui : OpClass_Auipc, AluFunc_Add,
                                      3'd0, 1'b1, 1'b1, {w[31:12], 12'd0}};
        7'b1101111: o = '{OpClass_Jal, AluFunc_Add, 3'd0, 1'b1, 1'b1,
                          {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0}};
        7'b1100111: if (f3 == 3'd0) o = '{OpClass_Jalr, AluFunc_Add, 3'd0, 1'b1, 1'b1, immI};
        7'b1100011: if (f3 != 3'd2 && f3 != 3'd3)
            o = '{OpClass_Branch, w[14] ? (w[13] ? AluFunc_Sltu : AluFunc_Slt) : AluFunc_Sub,
                  f3, 1'b0, 1'b0, {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0}};
        7'b0000011: if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5})
            o = '{OpClass_Load, AluFunc_Add, f3, 1'b1, 1'b1, immI};
        7'b0100011: if (f3 inside {3'd0, 3'd1, 3'd2})
            o = '{OpClass_Store, AluFunc_Add, f3, 1'b1, 1'b0, {{20{w[31]}}, w[31:25], w[11:7]}};
        7'b0010011: if ((f3 == 3'd1) ? (f7 == 7'h00) : (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20))
            o = '{OpClass_Alu, aluRef(f3 == 3'd5 && f7 == 7'h20, f3), 3'd0, 1'b1, 1'b1, immI};
        7'b0110011: if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
            o = '{OpClass_Alu, aluRef(f7 == 7'h20, f3), 3'd0, 1'b0, 1'b1, 32'd0};
        7'b1110011: if (f3[1:0] != 2'd0)  // the six csr forms
            o = '{OpClass_Csr, AluFunc_Add, f3, f3[2], 1'b1, f3[2] ? {27'd0, w[19:15]} : 32'd0};
        default: o.opClass = OpClass_Unknown;
    endcase
    return o;
endfunction

// operands come from the shadow file as it stands after the capturing edge
function automatic IssueOut expectIssue(addr_t pc, op_id_t id);
    IssueOut e;
    insn_t   w;
    w = mem[pc[9:2]];
    e = '0;
    e.valid       = 1'b1;
    e.pc          = pc;
    e.op          = refDecode(w);
    e.opId        = id;
    e.csrAddr     = w[31:20];
    e.srcRegAddr1 = w[19:15];
    e.srcRegAddr2 = w[24:20];
    e.dstRegAddr  = w[11:7];
    if (pc[1:0] != 2'b00) begin
        e.trapInfo = '{1'b1, ExceptionCode_InsnAddrMisaligned, pc};
    end
    else if (e.op.opClass == OpClass_Unknown) begin
        e.trapInfo = '{1'b1, ExceptionCode_IllegalInsn, w};
    end
    e.src1Value = shadowRead(e.srcRegAddr1);
    e.src2Value = shadowRead(e.srcRegAddr2);
    return e;
endfunction

`endif

/* tests/FrontEndTb.sv */
`timescale 1ns/1ps

module FrontEndTb;
    import FrontTypes::*;

    localparam int SetupCycles   = 40;
    localparam int MainCycles    = 960;
    localparam int TimeoutCycles = 2 * (SetupCycles + MainCycles);

    logic      clk;
    logic      rst;
    logic      stall;
    logic      flush;
    addr_t     flushPc;
    op_id_t    opCommitCount;
    addr_t     insnAddr;
    insn_t     insnData;
    logic      wbEnable;
    reg_addr_t wbAddr;
    data_t     wbData;
    IssueOut   issue;

    insn_t   mem [256];
    logic    edgeRst;       // controls seen at the last rising edge
    logic    edgeStall;
    logic    edgeFlush;
    addr_t   edgeFlushPc;
    op_id_t  edgeCount;
    IssueOut heldIssue;
    IssueOut want;
    addr_t   expPc;         // scoreboard of the in-order stream
    op_id_t  expOpId;
    int      issuedCount = 0;
    int      cycleCount  = 0;

    `include "FrontEndModel.svh"

    FrontEnd u_dut (.*);

    assign insnData = mem[insnAddr[9:2]];  // word addressed, answers in the same cycle

    always #4 clk = ~clk;

    task automatic reportFail(string name, logic [63:0] expected, logic [63:0] actual);
        $display("** Error: %s expected %0h actual %0h", name, expected, actual);
        $display("Done: errors found");
        $fatal(1, "%s check failed", name);
    endtask

    task automatic checkValue(string name, logic [63:0] expected, logic [63:0] actual);
        assert (actual == expected) else reportFail(name, expected, actual);
    endtask

    // random legal encoding of one kind, the last kind is a fence
    function automatic insn_t makeWord(int kind);
        insn_t      w;
        logic [2:0] f3;
        w  = $urandom;
        f3 = w[14:12];
        case (kind)
            0: w = {1'b0, w[7] & (f3 == 3'd0 || f3 == 3'd5), 5'b0, w[24:7], OpcodeOp};
            1: w = {(f3 == 3'd1 || f3 == 3'd5) ? {1'b0, w[7] & f3[2], 5'b0} : w[31:25],
                    w[24:7], OpcodeOpImm};
            2: w = {w[31:15], (f3[2:1] == 2'b11 || f3 == 3'd3) ? 3'd2 : f3, w[11:7], OpcodeLoad};
            3: w = {w[31:15], 1'b0, w[13], w[12] & ~w[13], w[11:7], OpcodeStore};
            4: w = {w[31:15], w[14] | w[13], w[13:7], OpcodeBranch};
            5: w = {w[31:7], OpcodeJal};
            6: w = {w[31:15], 3'd0, w[11:7], OpcodeJalr};
            7: w = {w[31:7], OpcodeLui};
            8: w = {w[31:7], OpcodeAuipc};
            9: w = {w[31:14], w[13], w[12] | ~w[13], w[11:7], OpcodeSystem};
            default: w = {w[31:7], 7'b0001111};
        endcase
        return w;
    endfunction

    always @(posedge clk) begin
        edgeRst     = rst;
        edgeStall   = stall;
        edgeFlush   = flush;
        edgeFlushPc = flushPc;
        edgeCount   = opCommitCount;
        if (wbEnable) shadowWrite(wbAddr, wbData);  // visible to the op captured here
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TimeoutCycles) begin
            $display("run did not finish within %0d cycles", TimeoutCycles);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    // issue is stable at the falling edge
    always @(negedge clk) begin
        if (edgeRst) begin
            expPc   = ResetPc;
            expOpId = '0;
        end
        else if (edgeFlush) begin
            checkValue("flushClear", 64'd0, issue.valid);
            expPc   = edgeFlushPc;
            expOpId = edgeCount;
        end
        else if (edgeStall) begin
            assert (issue == heldIssue)
                else reportFail("stallHold", {heldIssue.pc, heldIssue.opId},
                                {issue.pc, issue.opId});
        end
        else if (issue.valid) begin
            want = expectIssue(expPc, expOpId);
            checkValue("pcSequence", want.pc, issue.pc);
            checkValue("opIdSequence", want.opId, issue.opId);
            checkValue("decodeOp", want.op, issue.op);
            checkValue("csrAddr", want.csrAddr, issue.csrAddr);
            checkValue("srcRegAddr1", want.srcRegAddr1, issue.srcRegAddr1);
            checkValue("srcRegAddr2", want.srcRegAddr2, issue.srcRegAddr2);
            checkValue("dstRegAddr", want.dstRegAddr, issue.dstRegAddr);
            checkValue("trapInfo", want.trapInfo, issue.trapInfo);
            checkValue("src1Value", want.src1Value, issue.src1Value);
            checkValue("src2Value", want.src2Value, issue.src2Value);
            // fetch runs three words ahead of issue
            checkValue("fetchAhead", addr_t'(expPc + 32'd12), insnAddr);
            expPc   = expPc + addr_t'(4);
            expOpId = expOpId + op_id_t'(1);
            issuedCount++;
        end
        heldIssue = issue;
    end

    initial begin
        int stallLeft;
        void'($urandom(32'ha0a9));
        stallLeft     = 0;
        clk           = 1'b0;
        rst           = 1'b1;
        stall         = 1'b0;
        flush         = 1'b0;
        flushPc       = '0;
        opCommitCount = '0;
        wbEnable      = 1'b0;
        wbAddr        = '0;
        wbData        = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = makeWord($urandom_range(0, 10));
        end
        mem[0] = 32'h00000013;  // nop
        mem[1] = 32'hfe000033;  // register op with unknown funct7
        mem[2] = 32'hffffffff;  // unknown opcode
        repeat (3) @(negedge clk);
        rst      = 1'b0;
        stall    = 1'b1;        // empty pipeline waits while the register file fills
        wbEnable = 1'b1;
        for (int r = 0; r < 32; r++) begin
            wbAddr = reg_addr_t'(r);
            wbData = $urandom;
            @(negedge clk);
        end
        for (int i = 0; i < MainCycles; i++) begin
            flush = 1'b0;
            if (stallLeft > 0) begin
                stall = 1'b1;
                stallLeft--;
            end
            else begin
                stall = 1'b0;
                if ($urandom_range(0, 15) == 0) stallLeft = $urandom_range(1, 6);
            end
            if (i == 400 || $urandom_range(0, 39) == 0) begin
                flush         = 1'b1;
                flushPc       = addr_t'($urandom_range(0, 255)) << 2;
                opCommitCount = $urandom;
                if (i == 400 || $urandom_range(0, 3) == 0) flushPc[1:0] = 2'($urandom_range(1, 3));
            end
            wbEnable = $urandom_range(0, 1);
            // half the writes hit rs1 of the op now in decode
            wbAddr   = $urandom_range(0, 1) ? mem[insnAddr[9:2] - 8'd2][19:15]
                                            : reg_addr_t'($urandom);
            wbData   = $urandom;
            @(negedge clk);
        end
        stall    = 1'b0;
        flush    = 1'b0;
        wbEnable = 1'b0;
        repeat (4) @(negedge clk);
        if (issuedCount < MainCycles / 4) begin
            $display("too few operations issued: %0d", issuedCount);
            $display("Done: errors found");
            $fatal(1, "stimulus did not reach the checks");
        end
        else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* hdl/FrontEnd.sv */
`timescale 1ns/1ps

module FrontEnd (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  flush,
    input  FrontTypes::addr_t     flushPc,
    input  FrontTypes::op_id_t    opCommitCount,
    output FrontTypes::addr_t     insnAddr,
    input  FrontTypes::insn_t     insnData,
    input  logic                  wbEnable,
    input  FrontTypes::reg_addr_t wbAddr,
    input  FrontTypes::data_t     wbData,
    output FrontTypes::IssueOut   issue
);
    import FrontTypes::*;

    FetchOut  fetchOut;         // fetch to decode
    DecodeOut decodeOut;        // decode to register read

    FetchStage u_fetch (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .flush    (flush),
        .flushPc  (flushPc),
        .insnAddr (insnAddr),
        .insnData (insnData),
        .fetchOut (fetchOut)
    );

    DecodeStage u_decode (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .flush         (flush),
        .opCommitCount (opCommitCount),
        .fetchOut      (fetchOut),
        .decodeOut     (decodeOut)
    );

    RegReadStage u_regRead (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .flush     (flush),
        .decodeOut (decodeOut),
        .wbEnable  (wbEnable),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .issue     (issue)
    );

endmodule

/* hdl/RegReadStage.sv */
`timescale 1ns/1ps

module RegReadStage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  flush,
    input  FrontTypes::DecodeOut  decodeOut,
    input  logic                  wbEnable,
    input  FrontTypes::reg_addr_t wbAddr,
    input  FrontTypes::data_t     wbData,
    output FrontTypes::IssueOut   issue
);
    import FrontTypes::*;

    data_t   regFile [32];
    data_t   src1Value;
    data_t   src2Value;
    IssueOut nextIssue;

    // x0 reads zero, a same-cycle write is forwarded
    function automatic data_t readPort(reg_addr_t addr, data_t stored);
        data_t value;
        if (addr == '0) begin
            value = '0;
        end
        else if (wbEnable && wbAddr == addr) begin
            value = wbData;
        end
        else begin
            value = stored;
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (wbEnable && wbAddr != '0) begin
            regFile[wbAddr] <= wbData;  // writes to x0 are dropped
        end
    end

    always_comb begin
        src1Value = readPort(decodeOut.srcRegAddr1, regFile[decodeOut.srcRegAddr1]);
        src2Value = readPort(decodeOut.srcRegAddr2, regFile[decodeOut.srcRegAddr2]);
    end

    always_comb begin
        nextIssue.valid       = decodeOut.valid;
        nextIssue.pc          = decodeOut.pc;
        nextIssue.op          = decodeOut.op;
        nextIssue.opId        = decodeOut.opId;
        nextIssue.csrAddr     = decodeOut.csrAddr;
        nextIssue.srcRegAddr1 = decodeOut.srcRegAddr1;
        nextIssue.srcRegAddr2 = decodeOut.srcRegAddr2;
        nextIssue.dstRegAddr  = decodeOut.dstRegAddr;
        nextIssue.trapInfo    = decodeOut.trapInfo;
        nextIssue.src1Value   = src1Value;
        nextIssue.src2Value   = src2Value;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            issue <= '0;
        end
        else if (!stall) begin
            issue <= decodeOut.valid ? nextIssue : '0;
        end
    end

endmodule

/* hdl/DecodeStage.sv */
`timescale 1ns/1ps

module DecodeStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  logic                 flush,
    input  FrontTypes::op_id_t   opCommitCount,
    input  FrontTypes::FetchOut  fetchOut,
    output FrontTypes::DecodeOut decodeOut
);
    import FrontTypes::*;

    Op        op;
    TrapInfo  trapInfo;
    DecodeOut nextDecode;
    op_id_t   opId;             // number given to the next valid op

    OpDecoder u_decoder (
        .insn (fetchOut.insn),
        .op   (op)
    );

    always_comb begin
        // a fetch trap wins over the illegal-instruction check
        if (!fetchOut.trapInfo.valid && op.opClass == OpClass_Unknown) begin
            trapInfo.valid = 1'b1;
            trapInfo.cause = ExceptionCode_IllegalInsn;
            trapInfo.value = fetchOut.insn;
        end
        else begin
            trapInfo = fetchOut.trapInfo;
        end
    end

    always_comb begin
        nextDecode.valid       = fetchOut.valid;
        nextDecode.pc          = fetchOut.pc;
        nextDecode.insn        = fetchOut.insn;
        nextDecode.op          = op;
        nextDecode.opId        = opId;
        nextDecode.csrAddr     = fetchOut.insn[31:20];
        nextDecode.srcRegAddr1 = fetchOut.insn[19:15];
        nextDecode.srcRegAddr2 = fetchOut.insn[24:20];
        nextDecode.dstRegAddr  = fetchOut.insn[11:7];
        nextDecode.trapInfo    = trapInfo;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            decodeOut <= '0;
        end
        else if (!stall) begin
            decodeOut <= fetchOut.valid ? nextDecode : '0;  // bubbles load zeros
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            opId <= '0;
        end
        else if (flush) begin
            opId <= opCommitCount;  // resume after the last committed op
        end
        else if (!stall && fetchOut.valid) begin
            opId <= opId + op_id_t'(1);
        end
    end

endmodule

/* hdl/FetchStage.sv */
`timescale 1ns/1ps

module FetchStage (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                flush,
    input  FrontTypes::addr_t   flushPc,
    output FrontTypes::addr_t   insnAddr,
    input  FrontTypes::insn_t   insnData,
    output FrontTypes::FetchOut fetchOut
);
    import FrontTypes::*;

    addr_t   pc;
    FetchOut nextFetch;
    logic    misaligned;

    assign insnAddr   = pc;             // memory answers in the same cycle
    assign misaligned = (pc[1:0] != 2'b00);

    always_comb begin
        nextFetch.valid = 1'b1;         // every non-stalled cycle fetches
        nextFetch.pc    = pc;
        nextFetch.insn  = insnData;
        if (misaligned) begin
            nextFetch.trapInfo.valid = 1'b1;
            nextFetch.trapInfo.cause = ExceptionCode_InsnAddrMisaligned;
            nextFetch.trapInfo.value = pc;
        end
        else begin
            nextFetch.trapInfo = '0;
        end
    end

    // program counter follows the same stall/flush rules as the register
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= ResetPc;
        end
        else if (flush) begin
            pc <= flushPc;              // restart point from the controller
        end
        else if (!stall) begin
            pc <= pc + addr_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            fetchOut <= '0;
        end
        else if (!stall) begin
            fetchOut <= nextFetch;
        end
    end

endmodule

/* hdl/OpDecoder.sv */
`timescale 1ns/1ps

module OpDecoder (
    input  FrontTypes::insn_t insn,
    output FrontTypes::Op     op
);
    import FrontTypes::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    data_t      immI;
    data_t      immS;
    data_t      immB;
    data_t      immU;
    data_t      immJ;
    data_t      zimm;

    assign opcode = insn[6:0];
    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];

    assign immI = {{20{insn[31]}}, insn[31:20]};
    assign immS = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    assign immB = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign immU = {insn[31:12], 12'b0};
    assign immJ = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    assign zimm = {27'b0, insn[19:15]};  // csr immediate sits in the rs1 field

    // shared by op and op-imm, alt selects sub/sra
    function automatic AluFunc aluFromFunct3(logic [2:0] f3, logic alt);
        AluFunc func;
        case (f3)
            3'b000:  func = alt ? AluFunc_Sub : AluFunc_Add;
            3'b001:  func = AluFunc_Sll;
            3'b010:  func = AluFunc_Slt;
            3'b011:  func = AluFunc_Sltu;
            3'b100:  func = AluFunc_Xor;
            3'b101:  func = alt ? AluFunc_Sra : AluFunc_Srl;
            3'b110:  func = AluFunc_Or;
            default: func = AluFunc_And;
        endcase
        return func;
    endfunction

    always_comb begin
        op         = '0;
        op.opClass = OpClass_Unknown;   // overwritten by any legal form
        case (opcode)
            OpcodeLui, OpcodeAuipc: begin
                op.opClass  = (opcode == OpcodeLui) ? OpClass_Lui : OpClass_Auipc;
                op.useImm   = 1'b1;
                op.writesRd = 1'b1;
                op.imm      = immU;
            end
            OpcodeJal: begin
                op.opClass  = OpClass_Jal;
                op.useImm   = 1'b1;
                op.writesRd = 1'b1;
                op.imm      = immJ;
            end
            OpcodeJalr: if (funct3 == 3'b000) begin
                op.opClass  = OpClass_Jalr;
                op.useImm   = 1'b1;
                op.writesRd = 1'b1;
                op.imm      = immI;
            end
            OpcodeBranch: if (funct3[2:1] != 2'b01) begin
                op.opClass = OpClass_Branch;
                op.funct3  = funct3;
                op.imm     = immB;
                // eq/ne by subtract, then signed and unsigned compare
                op.aluFunc = (funct3[2:1] == 2'b00) ? AluFunc_Sub :
                             (funct3[2:1] == 2'b10) ? AluFunc_Slt : AluFunc_Sltu;
            end
            OpcodeLoad: if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
                op.opClass  = OpClass_Load;
                op.funct3   = funct3;
                op.useImm   = 1'b1;
                op.writesRd = 1'b1;
                op.imm      = immI;
            end
            OpcodeStore: if (funct3[2] == 1'b0 && funct3 != 3'b011) begin
                op.opClass = OpClass_Store;
                op.funct3  = funct3;
                op.useImm  = 1'b1;
                op.imm     = immS;
            end
            OpcodeOpImm: if ((funct3 != 3'b001 && funct3 != 3'b101) || funct7 == Funct7Base ||
                             (funct3 == 3'b101 && funct7 == Funct7Alt)) begin
                op.opClass  = OpClass_Alu;
                op.aluFunc  = aluFromFunct3(funct3, funct3 == 3'b101 && funct7 == Funct7Alt);
                op.useImm   = 1'b1;
                op.writesRd = 1'b1;
                op.imm      = immI;
            end
            OpcodeOp: if (funct7 == Funct7Base ||
                          (funct7 == Funct7Alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                op.opClass  = OpClass_Alu;
                op.aluFunc  = aluFromFunct3(funct3, funct7 == Funct7Alt);
                op.writesRd = 1'b1;
            end
            OpcodeSystem: if (funct3[1:0] != 2'b00) begin  // csrrw/s/c and imm forms
                op.opClass  = OpClass_Csr;
                op.funct3   = funct3;
                op.useImm   = funct3[2];
                op.writesRd = 1'b1;
                op.imm      = funct3[2] ? zimm : '0;
            end
            default: begin
                op.opClass = OpClass_Unknown;               // fence and anything else
            end
        endcase
    end

endmodule

/* hdl/FrontTypes.sv */
package FrontTypes;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] insn_t;
    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] op_id_t;

    localparam addr_t ResetPc = '0;  // first fetch address after reset

    // RV32I major opcodes handled by the decoder
    localparam logic [6:0] OpcodeLoad   = 7'b0000011;
    localparam logic [6:0] OpcodeOpImm  = 7'b0010011;
    localparam logic [6:0] OpcodeAuipc  = 7'b0010111;
    localparam logic [6:0] OpcodeStore  = 7'b0100011;
    localparam logic [6:0] OpcodeOp     = 7'b0110011;
    localparam logic [6:0] OpcodeLui    = 7'b0110111;
    localparam logic [6:0] OpcodeBranch = 7'b1100011;
    localparam logic [6:0] OpcodeJalr   = 7'b1100111;
    localparam logic [6:0] OpcodeJal    = 7'b1101111;
    localparam logic [6:0] OpcodeSystem = 7'b1110011;

    localparam logic [6:0] Funct7Base = 7'b0000000;
    localparam logic [6:0] Funct7Alt  = 7'b0100000;  // sub and sra

    typedef enum logic [3:0] {
        OpClass_Alu, OpClass_Load, OpClass_Store, OpClass_Branch, OpClass_Jal,
        OpClass_Jalr, OpClass_Lui, OpClass_Auipc, OpClass_Csr, OpClass_Unknown
    } OpClass;

    typedef enum logic [3:0] {
        AluFunc_Add, AluFunc_Sub, AluFunc_Sll, AluFunc_Slt, AluFunc_Sltu,
        AluFunc_Xor, AluFunc_Srl, AluFunc_Sra, AluFunc_Or, AluFunc_And
    } AluFunc;

    // cause values follow the mcause numbering
    typedef enum logic [3:0] {
        ExceptionCode_InsnAddrMisaligned = 4'd0,
        ExceptionCode_IllegalInsn        = 4'd2,
        ExceptionCode_None               = 4'd15
    } ExceptionCode;

    typedef struct packed {
        OpClass     opClass;
        AluFunc     aluFunc;
        logic [2:0] funct3;    // access size or branch condition
        logic       useImm;    // second operand is imm
        logic       writesRd;
        data_t      imm;       // sign extended
    } Op;

    typedef struct packed {
        logic         valid;
        ExceptionCode cause;
        data_t        value;
    } TrapInfo;

    typedef struct packed {
        logic    valid;
        addr_t   pc;
        insn_t   insn;
        TrapInfo trapInfo;
    } FetchOut;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        insn_t     insn;
        Op         op;
        op_id_t    opId;
        csr_addr_t csrAddr;
        reg_addr_t srcRegAddr1;
        reg_addr_t srcRegAddr2;
        reg_addr_t dstRegAddr;
        TrapInfo   trapInfo;
    } DecodeOut;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        Op         op;
        op_id_t    opId;
        csr_addr_t csrAddr;
        reg_addr_t srcRegAddr1;
        reg_addr_t srcRegAddr2;
        reg_addr_t dstRegAddr;
        TrapInfo   trapInfo;
        data_t     src1Value;
        data_t     src2Value;
    } IssueOut;

endpackage
